//--- common/subterranean_pkg.sv
/*
 * Shared types and constants for the Subterranean stream control sequencer.
 * Only key loading and encryption are supported; hash and decrypt opcodes
 * are listed so the sequencer can reject them as illegal.
 */
package subterranean_pkg;

    // Cipher constants
    localparam int BLANK_ROUNDS = 8;
    localparam int TAG_WORDS    = 4;
    localparam int WORD_BYTES   = 4;
    localparam int CTR_W        = 4;

    // Instruction opcodes
    typedef enum logic [3:0] {
        op_encrypt = 4'b0010,
        op_decrypt = 4'b0011,
        op_key     = 4'b0100,
        op_key_alt = 4'b0111,
        op_hash    = 4'b1000
    } inst_op_e;

    // Sequencer states, grouped by phase
    typedef enum logic [4:0] {
        st_reset,
        st_idle,
        st_key_stream,
        st_key_last,
        st_key_pad,
        st_nonce_stream,
        st_nonce_last,
        st_nonce_pad,
        st_blank_start,
        st_blank_run,
        st_blank_end,
        st_ad_stream,
        st_ad_last,
        st_ad_pad,
        st_text_stream,
        st_text_last,
        st_text_pad,
        st_tag_start,
        st_tag_run,
        st_tag_end
    } seq_state_e;

    // Permutation core input select
    typedef enum logic [1:0] {
        cd_hold  = 2'b00,
        cd_null  = 2'b01,  // absorb an empty block
        cd_data  = 2'b10,  // absorb the buffered word
        cd_blank = 2'b11
    } core_din_e;

    typedef enum logic [1:0] {
        cm_plain       = 2'b00,
        cm_squeeze     = 2'b01,
        cm_duplex_text = 2'b10
    } core_mode_e;

    typedef enum logic [1:0] {
        ds_none = 2'b00,
        ds_text = 2'b01,
        ds_tag  = 2'b10
    } dout_sel_e;

    typedef struct packed {
        logic       init;
        core_din_e  din_sel;
        core_mode_e mode;
    } core_ctrl_t;

    // Size counts valid bytes of the word, 0 to WORD_BYTES
    typedef struct packed {
        logic                      valid;
        logic                      last;
        logic [2:0]                size;
        logic [WORD_BYTES*8-1:0]   data;
    } din_word_t;

endpackage

//--- logic/buffer_tracker.sv
/*
 * Data-in acceptance and padding decision. During the text phase input is
 * only taken when the output side is ready, so no text word is dropped.
 * The pad decision holds until the next last word arrives.
 */
module buffer_tracker (
    input  logic                        clk,
    input  logic                        arstn,
    input  subterranean_pkg::din_word_t din,
    input  logic                        stream_en,
    input  logic                        text_phase,
    input  logic                        dout_ready,
    output logic                        din_ready,
    output logic                        din_fire,
    output logic                        last_fire,
    output logic                        pad_needed
);
    import subterranean_pkg::*;

    // Byte count of the most recent last word
    logic [2:0] last_size;

    assign din_ready = stream_en & (~text_phase | dout_ready);
    assign din_fire  = din.valid & din_ready;
    assign last_fire = din_fire & din.last;

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            last_size <= 3'd0;
        end else if (last_fire) begin
            last_size <= din.size;
        end
    end

    // Empty or full last word needs an extra null block
    assign pad_needed = (last_size == 3'd0) || (last_size == 3'(WORD_BYTES));

endmodule

//--- logic/round_counter.sv
/*
 * Loadable down-counter shared by the blank run and the tag output.
 * A load wins over a step in the same cycle.
 */
module round_counter (
    input  logic clk,
    input  logic arstn,
    input  logic ctr_load_blank,
    input  logic ctr_load_tag,
    input  logic ctr_step,
    output logic ctr_is_one
);
    import subterranean_pkg::*;

    logic [CTR_W-1:0] count;

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            count <= '0;
        end else if (ctr_load_blank) begin
            // Blank start consumes one step before the run
            count <= CTR_W'(BLANK_ROUNDS - 1);
        end else if (ctr_load_tag) begin
            count <= CTR_W'(TAG_WORDS);
        end else if (ctr_step) begin
            count <= count - 1'b1;
        end
    end

    // Final step of the run
    assign ctr_is_one = (count == CTR_W'(1));

endmodule

//--- sequencer/sequencer_fsm.sv
/*
 * Main control FSM. All control outputs are decoded from the next state and
 * registered, so they are valid in the first cycle of their state.
 * Text-phase dout_valid follows accepted input words combinationally.
 */
module sequencer_fsm (
    input  logic                         clk,
    input  logic                         arstn,
    input  subterranean_pkg::inst_op_e   inst,
    input  logic                         inst_valid,
    output logic                         inst_ready,
    input  logic                         din_fire,
    input  logic                         last_fire,
    input  logic                         pad_needed,
    input  logic                         ctr_is_one,
    input  logic                         dout_ready,
    output logic                         stream_en,
    output logic                         text_phase,
    output logic                         ctr_load_blank,
    output logic                         ctr_load_tag,
    output logic                         ctr_step,
    output logic                         dout_valid,
    output subterranean_pkg::dout_sel_e  dout_sel,
    output subterranean_pkg::core_ctrl_t core_ctrl
);
    import subterranean_pkg::*;

    seq_state_e state;
    seq_state_e next_state;
    // Set once the text phase is done, so the next blank run leads to the tag
    logic       tag_pending;
    logic       tag_valid;
    logic       inst_fire;
    logic       tag_beat;
    logic       next_inst_ready;
    logic       next_stream_en;
    logic       next_text_phase;
    logic       next_tag_valid;
    dout_sel_e  next_dout_sel;
    core_ctrl_t next_core_ctrl;

    assign inst_fire = inst_valid & inst_ready;
    assign tag_beat  = tag_valid & dout_ready;

    // Text output beat rises with each accepted text word
    assign dout_valid = tag_valid | (text_phase & din_fire);

    // Counter strobes
    assign ctr_load_blank = (next_state == st_blank_start);
    assign ctr_load_tag   = (next_state == st_tag_start) && (state != st_tag_start);
    assign ctr_step       = (state == st_blank_start) || (state == st_blank_run) || tag_beat;

    always_comb begin
        next_state = state;
        case (state)
            st_reset : begin
                next_state = st_idle;
            end
            st_idle : begin
                if (inst_fire) begin
                    case (inst)
                        op_encrypt : next_state = st_nonce_stream;
                        op_key, op_key_alt : next_state = st_key_stream;
                        default : next_state = st_reset;
                    endcase
                end
            end
            st_key_stream : begin
                if (last_fire) begin
                    next_state = st_key_last;
                end
            end
            st_key_last : begin
                next_state = pad_needed ? st_key_pad : st_idle;
            end
            st_key_pad : begin
                next_state = st_idle;
            end
            st_nonce_stream : begin
                if (last_fire) begin
                    next_state = st_nonce_last;
                end
            end
            st_nonce_last : begin
                next_state = pad_needed ? st_nonce_pad : st_blank_start;
            end
            st_nonce_pad : begin
                next_state = st_blank_start;
            end
            st_blank_start : begin
                next_state = st_blank_run;
            end
            st_blank_run : begin
                if (ctr_is_one) begin
                    next_state = st_blank_end;
                end
            end
            st_blank_end : begin
                next_state = tag_pending ? st_tag_start : st_ad_stream;
            end
            st_ad_stream : begin
                if (last_fire) begin
                    next_state = st_ad_last;
                end
            end
            st_ad_last : begin
                next_state = pad_needed ? st_ad_pad : st_text_stream;
            end
            st_ad_pad : begin
                next_state = st_text_stream;
            end
            st_text_stream : begin
                if (last_fire) begin
                    next_state = st_text_last;
                end
            end
            st_text_last : begin
                next_state = pad_needed ? st_text_pad : st_blank_start;
            end
            st_text_pad : begin
                next_state = st_blank_start;
            end
            // Stalls hold the state, only accepted beats move on
            st_tag_start, st_tag_run : begin
                if (tag_beat) begin
                    next_state = ctr_is_one ? st_tag_end : st_tag_run;
                end
            end
            st_tag_end : begin
                next_state = st_reset;
            end
            default : begin
                next_state = st_reset;
            end
        endcase
    end

    // Output decode from the next state
    always_comb begin
        next_inst_ready = 1'b0;
        next_stream_en  = 1'b0;
        next_text_phase = 1'b0;
        next_tag_valid  = 1'b0;
        next_dout_sel   = ds_none;
        next_core_ctrl  = '{init: 1'b0, din_sel: cd_hold, mode: cm_plain};
        case (next_state)
            st_reset : begin
                next_core_ctrl.init = 1'b1;
            end
            st_idle : begin
                next_inst_ready = 1'b1;
            end
            st_key_stream, st_nonce_stream, st_ad_stream : begin
                next_stream_en         = 1'b1;
                next_core_ctrl.din_sel = cd_data;
            end
            st_text_stream : begin
                next_stream_en         = 1'b1;
                next_text_phase        = 1'b1;
                next_dout_sel          = ds_text;
                next_core_ctrl.din_sel = cd_data;
                next_core_ctrl.mode    = cm_duplex_text;
            end
            st_key_last, st_nonce_last, st_ad_last : begin
                next_core_ctrl.din_sel = cd_data;
            end
            st_text_last : begin
                next_core_ctrl.din_sel = cd_data;
                next_core_ctrl.mode    = cm_duplex_text;
            end
            st_key_pad, st_nonce_pad, st_ad_pad, st_text_pad : begin
                next_core_ctrl.din_sel = cd_null;
            end
            st_blank_start, st_blank_run, st_blank_end : begin
                next_core_ctrl.din_sel = cd_blank;
            end
            // Core squeezes one tag word per accepted beat
            st_tag_start, st_tag_run : begin
                next_tag_valid      = 1'b1;
                next_dout_sel       = ds_tag;
                next_core_ctrl.mode = cm_squeeze;
            end
            default : begin
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            state       <= st_reset;
            inst_ready  <= 1'b0;
            stream_en   <= 1'b0;
            text_phase  <= 1'b0;
            tag_valid   <= 1'b0;
            dout_sel    <= ds_none;
            core_ctrl   <= '{init: 1'b1, din_sel: cd_hold, mode: cm_plain};
        end else begin
            state       <= next_state;
            inst_ready  <= next_inst_ready;
            stream_en   <= next_stream_en;
            text_phase  <= next_text_phase;
            tag_valid   <= next_tag_valid;
            dout_sel    <= next_dout_sel;
            core_ctrl   <= next_core_ctrl;
        end
    end

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            tag_pending <= 1'b0;
        end else if (state == st_idle) begin
            tag_pending <= 1'b0;
        end else if (state == st_text_last) begin
            tag_pending <= 1'b1;
        end
    end

endmodule

//--- logic/stream_ctrl_top.sv
/*
 * Top of the stream control sequencer. Drives the permutation core and
 * output buffer controls; the datapath itself lives outside this block.
 */
module stream_ctrl_top (
    input  logic                         clk,
    input  logic                         arstn,
    input  subterranean_pkg::inst_op_e   inst,
    input  logic                         inst_valid,
    output logic                         inst_ready,
    input  subterranean_pkg::din_word_t  din,
    output logic                         din_ready,
    input  logic                         dout_ready,
    output logic                         dout_valid,
    output subterranean_pkg::dout_sel_e  dout_sel,
    output subterranean_pkg::core_ctrl_t core_ctrl
);

    logic stream_en;
    logic text_phase;
    logic din_fire;
    logic last_fire;
    logic pad_needed;
    logic ctr_load_blank;
    logic ctr_load_tag;
    logic ctr_step;
    logic ctr_is_one;

    buffer_tracker u_buffer_tracker (
        .clk        (clk),
        .arstn      (arstn),
        .din        (din),
        .stream_en  (stream_en),
        .text_phase (text_phase),
        .dout_ready (dout_ready),
        .din_ready  (din_ready),
        .din_fire   (din_fire),
        .last_fire  (last_fire),
        .pad_needed (pad_needed)
    );

    round_counter u_round_counter (
        .clk            (clk),
        .arstn          (arstn),
        .ctr_load_blank (ctr_load_blank),
        .ctr_load_tag   (ctr_load_tag),
        .ctr_step       (ctr_step),
        .ctr_is_one     (ctr_is_one)
    );

    sequencer_fsm u_sequencer_fsm (
        .clk            (clk),
        .arstn          (arstn),
        .inst           (inst),
        .inst_valid     (inst_valid),
        .inst_ready     (inst_ready),
        .din_fire       (din_fire),
        .last_fire      (last_fire),
        .pad_needed     (pad_needed),
        .ctr_is_one     (ctr_is_one),
        .dout_ready     (dout_ready),
        .stream_en      (stream_en),
        .text_phase     (text_phase),
        .ctr_load_blank (ctr_load_blank),
        .ctr_load_tag   (ctr_load_tag),
        .ctr_step       (ctr_step),
        .dout_valid     (dout_valid),
        .dout_sel       (dout_sel),
        .core_ctrl      (core_ctrl)
    );

endmodule

//--- sim/tb_tasks.svh
/*
 * Driver, check and directed-test tasks, included inside tb_stream_ctrl.
 * Drivers start on a drive point just after a rising edge.
 */
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
endfunction

task automatic check_eq(input string name, input logic [31:0] actual,
                        input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("[FAIL] t=%0t %s expected %0h got %0h", $time, name, expected, actual);
    end
endtask

task automatic report_error(input string msg);
    errors++;
    $display("ERROR t=%0t %s", $time, msg);
endtask

task automatic end_test(input string name, input int errors_at_start);
    $display("%-12s done, %0d errors", name, errors - errors_at_start);
endtask

task automatic to_drive_point();
    @(posedge clk);
    #(DRIVE_DLY);
endtask

task automatic issue_inst(input inst_op_e op);
    int waited = 0;
    to_drive_point();
    inst       = op;
    inst_valid = 1'b1;
    @(negedge clk);
    while (!inst_ready && waited < WAIT_LIMIT) begin
        waited++;
        @(negedge clk);
    end
    if (!inst_ready) begin
        report_error("instruction was never accepted");
    end
    to_drive_point();
    inst_valid = 1'b0;
endtask

task automatic send_words(input int count, input logic [2:0] last_size);
    int waited;
    for (int i = 0; i < count; i++) begin
        din.valid = 1'b1;
        din.last  = (i == count - 1);
        din.size  = (i == count - 1) ? last_size : 3'(WORD_BYTES);
        din.data  = 32'(i + 1);
        waited    = 0;
        @(negedge clk);
        while (!din_ready && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (!din_ready) begin
            report_error("input word was never accepted");
        end
        to_drive_point();
    end
    din = '0;
endtask

task automatic test_reset();
    int start_err = errors;
    repeat (4) begin
        to_drive_point();
        check_eq("inst_ready", inst_ready, 0);
        check_eq("din_ready", din_ready, 0);
        check_eq("dout_valid", dout_valid, 0);
        check_eq("core_ctrl.init", core_ctrl.init, 1);
    end
    arstn = 1'b1;
    @(negedge clk);
    check_eq("inst_ready", inst_ready, 0);
    @(negedge clk);
    check_eq("inst_ready", inst_ready, 1);
    end_test("reset", start_err);
endtask

task automatic test_key_load(input inst_op_e op, input logic [2:0] last_size,
                             input int exp_pads);
    int start_err = errors;
    int pads = 0;
    int waited = 0;
    issue_inst(op);
    send_words(1 + lcg_next() % 4, last_size);
    @(negedge clk);
    while (!inst_ready && waited < WAIT_LIMIT) begin
        if (core_ctrl.din_sel == cd_null) begin
            pads++;
        end
        waited++;
        @(negedge clk);
    end
    if (!inst_ready) begin
        report_error("inst_ready did not return after key load");
    end
    check_eq("cd_null cycles", pads, exp_pads);
    end_test("key_load", start_err);
endtask

task automatic test_illegal(input inst_op_e op);
    int start_err = errors;
    int cycles = 0;
    issue_inst(op);
    do begin
        @(negedge clk);
        cycles++;
        check_eq("din_ready", din_ready, 0);
    end while (!inst_ready && cycles < 2);
    if (!inst_ready) begin
        report_error("inst_ready not back within 2 cycles of an illegal opcode");
    end
    end_test("illegal_op", start_err);
endtask

task automatic test_nonce_blank();
    int start_err = errors;
    int blanks = 0;
    int waited = 0;
    issue_inst(op_encrypt);
    send_words(1 + lcg_next() % 6, 3'(WORD_BYTES));
    @(negedge clk);
    // Count the first unbroken run of blank rounds
    while (waited < WAIT_LIMIT && !(blanks > 0 && core_ctrl.din_sel != cd_blank)) begin
        if (core_ctrl.din_sel == cd_blank) begin
            blanks++;
        end
        waited++;
        @(negedge clk);
    end
    check_eq("cd_blank cycles", blanks, BLANK_ROUNDS);
    end_test("nonce_blank", start_err);
endtask

task automatic test_text_stall();
    int start_err = errors;
    int words;
    int beats_at_start;
    to_drive_point();
    // Associated data, then text under random back-pressure
    send_words(1 + lcg_next() % 4, 3'd1);
    words          = 1 + lcg_next() % 6;
    beats_at_start = text_beats;
    stall_en       = 1'b1;
    send_words(words, 3'd3);
    stall_en = 1'b0;
    check_eq("text beats", text_beats - beats_at_start, words);
    end_test("text_stall", start_err);
endtask

task automatic test_tag_stall();
    int start_err = errors;
    int beats_at_start = tag_beats;
    int waited = 0;
    stall_en = 1'b1;
    @(negedge clk);
    while (!inst_ready && waited < WAIT_LIMIT) begin
        waited++;
        @(negedge clk);
    end
    if (!inst_ready) begin
        report_error("inst_ready did not return after the tag output");
    end
    to_drive_point();
    stall_en = 1'b0;
    check_eq("tag beats", tag_beats - beats_at_start, TAG_WORDS);
    end_test("tag_stall", start_err);
endtask

`endif

//--- sim/tb_stream_ctrl.sv
/*
 * Directed testbench for stream_ctrl_top. Word counts and output stalls
 * come from a fixed-seed LCG, and a watchdog bounds the run time.
 */
module tb_stream_ctrl;
    import subterranean_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DLY  = 2;
    localparam int WAIT_LIMIT = 64;
    // Cycle budget per test, in test order
    localparam int TEST_CYCLES = 8 + 3 * 14 + 2 * 6 + 30 + 30 + 30;

    logic       clk;
    logic       arstn;
    inst_op_e   inst;
    logic       inst_valid;
    logic       inst_ready;
    din_word_t  din;
    logic       din_ready;
    logic       dout_ready;
    logic       dout_valid;
    dout_sel_e  dout_sel;
    core_ctrl_t core_ctrl;

    int unsigned lcg_state;
    logic        stall_en;
    logic        stall_bit;
    int          errors;
    int          checks;
    int          text_beats;
    int          tag_beats;

    stream_ctrl_top DUT (
        .clk        (clk),
        .arstn      (arstn),
        .inst       (inst),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .din        (din),
        .din_ready  (din_ready),
        .dout_ready (dout_ready),
        .dout_valid (dout_valid),
        .dout_sel   (dout_sel),
        .core_ctrl  (core_ctrl)
    );

    `include "tb_tasks.svh"

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Back-pressure drawn at the edge, driven after the drive delay
    always @(posedge clk) begin
        stall_bit = stall_en && (lcg_next() % 4 == 0);
        #(DRIVE_DLY);
        dout_ready = ~stall_bit;
    end

    // Beat counters, the text pass-through rule and the core mode per phase
    always @(negedge clk) begin
        if (arstn) begin
            if (dout_sel == ds_text) begin
                check_eq("din_ready", din_ready, dout_ready);
                check_eq("core_ctrl.mode", core_ctrl.mode, cm_duplex_text);
            end
            if (dout_sel == ds_tag) begin
                check_eq("core_ctrl.mode", core_ctrl.mode, cm_squeeze);
            end
            if (dout_valid && dout_ready && dout_sel == ds_text) begin
                text_beats++;
            end
            if (dout_valid && dout_ready && dout_sel == ds_tag) begin
                tag_beats++;
            end
        end
    end

    initial begin
        #(TEST_CYCLES * 4 * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, DUT stopped responding", TEST_CYCLES * 4);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        clk        = 1'b0;
        arstn      = 1'b0;
        inst       = op_key;
        inst_valid = 1'b0;
        din        = '0;
        dout_ready = 1'b1;
        stall_en   = 1'b0;
        stall_bit  = 1'b0;
        lcg_state  = 32'd87606;
        errors     = 0;
        checks     = 0;
        text_beats = 0;
        tag_beats  = 0;

        test_reset();
        test_key_load(op_key, 3'd4, 1);
        test_key_load(op_key_alt, 3'd2, 0);
        test_key_load(op_key, 3'd0, 1);
        test_illegal(op_hash);
        test_illegal(op_decrypt);
        // One encryption, split into its phases
        test_nonce_blank();
        test_text_stall();
        test_tag_stall();

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+sim
common/subterranean_pkg.sv
logic/buffer_tracker.sv
logic/round_counter.sv
sequencer/sequencer_fsm.sv
logic/stream_ctrl_top.sv
sim/tb_stream_ctrl.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := tb_stream_ctrl
FILELIST  := sim.f

SRCS := $(shell grep -v '^+' $(FILELIST)) sim/tb_tasks.svh
BIN  := obj_dir/V$(TOP)
LOG  := sim.log

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "ALL CHECKS PASSED" $(LOG); then echo "Simulation incomplete"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
